// File: common/periph_pkg.sv
// Peripheral subsystem shared definitions
// Bus widths, address map, response codes and register request/response types

package periph_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int OFFS_W = 8;  // Word offset field inside a window

    // ----------------------------------------
    // Address map, slot is addr[11:8]
    // ----------------------------------------
    localparam logic [3:0] SLOT_TIMER = 4'd0;
    localparam logic [3:0] SLOT_IRQ   = 4'd1;

    localparam logic [DATA_W-1:0] ABSENT_DATA = 32'hDEADBEEF;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        TIMER  = 2'd0,
        IRQ    = 2'd1,
        ABSENT = 2'd2
    } slot_e;

    // One register access, valid for a single cycle
    typedef struct packed {
        logic              valid;
        logic              write;
        slot_e             slot;
        logic [OFFS_W-1:0] offset;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } reg_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic [1:0]        resp;
    } reg_rsp_t;

    // Byte lane merge of write data into an existing register
    function automatic logic [DATA_W-1:0] apply_strb(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] wstrb
    );
        logic [DATA_W-1:0] merged;
        merged = old_val;
        for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) merged[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return merged;
    endfunction

endpackage

// File: logic/axil_reg_bridge.sv
// AXI4-Lite slave front end
// Accepts one write or read at a time, decodes the target window and
// issues a single-cycle register request, then returns the response on B or R

`timescale 1ns/1ps

module axil_reg_bridge
    import periph_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    // Write address and data
    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [STRB_W-1:0] wstrb_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    // Write response
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    // Read address and data
    input  logic [ADDR_W-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,
    // Register side
    input  reg_rsp_t          rsp_i,
    output reg_req_t          req_o
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_RESP  = 2'd2
    } state_e;

    state_e            state_q;
    logic              write_q;
    slot_e             slot_q;
    logic [OFFS_W-1:0] offset_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;

    logic              wr_accept;
    logic              rd_accept;
    logic              resp_done;
    logic [ADDR_W-1:0] addr_sel;

    function automatic slot_e decode_slot(input logic [ADDR_W-1:0] addr);
        case (addr[11:8])
            SLOT_TIMER: return TIMER;
            SLOT_IRQ:   return IRQ;
            default:    return ABSENT;
        endcase
    endfunction

    // Write needs AW and W together and wins over a read
    assign wr_accept = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
    assign rd_accept = (state_q == ST_IDLE) && arvalid_i && !(awvalid_i && wvalid_i);
    assign addr_sel  = wr_accept ? awaddr_i : araddr_i;

    assign awready_o = wr_accept;
    assign wready_o  = wr_accept;
    assign arready_o = rd_accept;

    assign bvalid_o = (state_q == ST_RESP) && write_q;
    assign rvalid_o = (state_q == ST_RESP) && !write_q;
    assign bresp_o  = rsp_i.resp;
    assign rresp_o  = rsp_i.resp;
    assign rdata_o  = rsp_i.rdata;

    assign resp_done = (bvalid_o && bready_i) || (rvalid_o && rready_i);

    // ----------------------------------------
    // Transaction FSM
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            write_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state_q <= ST_ISSUE;
                        write_q <= wr_accept;
                    end
                end
                ST_ISSUE: state_q <= ST_RESP;      // Response select samples here
                ST_RESP:  if (resp_done) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // Captured access
    always_ff @(posedge clk_i) begin
        if (wr_accept || rd_accept) begin
            slot_q   <= decode_slot(addr_sel);
            offset_q <= OFFS_W'(addr_sel[7:2]);
            wdata_q  <= wdata_i;
            wstrb_q  <= wr_accept ? wstrb_i : '0;
        end
    end

    assign req_o.valid  = (state_q == ST_ISSUE);
    assign req_o.write  = write_q;
    assign req_o.slot   = slot_q;
    assign req_o.offset = offset_q;
    assign req_o.wdata  = wdata_q;
    assign req_o.wstrb  = wstrb_q;

endmodule

// File: timer/timer_bank.sv
// Bank of match timers
// Each timer has counter, compare, control and status words at 16-byte stride;
// a match wraps the counter and raises the timer's interrupt line

`timescale 1ns/1ps

module timer_bank
    import periph_pkg::*;
#(
    parameter int NUM_TIMERS = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  reg_req_t              req_i,
    output reg_rsp_t              rsp_o,
    output logic [NUM_TIMERS-1:0] tmr_irq_o
);

    localparam logic [1:0] REG_COUNT   = 2'd0;
    localparam logic [1:0] REG_COMPARE = 2'd1;
    localparam logic [1:0] REG_CONTROL = 2'd2;
    localparam logic [1:0] REG_STATUS  = 2'd3;

    logic [DATA_W-1:0]     count_q   [NUM_TIMERS];
    logic [DATA_W-1:0]     compare_q [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] enable_q;
    logic [NUM_TIMERS-1:0] match_q;

    logic       wr_en;
    logic [5:0] sel_idx;   // Timer number
    logic [1:0] sel_reg;   // Word within timer

    assign wr_en   = req_i.valid && req_i.write && (req_i.slot == TIMER);
    assign sel_idx = req_i.offset[7:2];
    assign sel_reg = req_i.offset[1:0];

    assign tmr_irq_o = match_q;

    // ----------------------------------------
    // Counters and register writes
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                count_q[i]   <= '0;
                compare_q[i] <= '0;
            end
            enable_q <= '0;
            match_q  <= '0;
        end else begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                if (enable_q[i]) begin
                    if (count_q[i] == compare_q[i]) begin
                        count_q[i] <= '0;
                        match_q[i] <= 1'b1;
                    end else begin
                        count_q[i] <= count_q[i] + DATA_W'(1);
                    end
                end
                // Bus write overrides counting in the same cycle
                if (wr_en && (sel_idx == 6'(i))) begin
                    case (sel_reg)
                        REG_COUNT:
                            count_q[i] <= apply_strb(count_q[i], req_i.wdata, req_i.wstrb);
                        REG_COMPARE:
                            compare_q[i] <= apply_strb(compare_q[i], req_i.wdata, req_i.wstrb);
                        REG_CONTROL:
                            if (req_i.wstrb[0]) enable_q[i] <= req_i.wdata[0];
                        REG_STATUS:
                            if (req_i.wstrb[0] && req_i.wdata[0]) match_q[i] <= 1'b0; // W1C
                    endcase
                end
            end
        end
    end

    // Read mux with zero for unused offsets
    always_comb begin
        rsp_o.rdata = '0;
        rsp_o.resp  = RESP_OKAY;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (sel_idx == 6'(i)) begin
                case (sel_reg)
                    REG_COUNT:   rsp_o.rdata = count_q[i];
                    REG_COMPARE: rsp_o.rdata = compare_q[i];
                    REG_CONTROL: rsp_o.rdata = DATA_W'(enable_q[i]);
                    REG_STATUS:  rsp_o.rdata = DATA_W'(match_q[i]);
                endcase
            end
        end
    end

endmodule

// File: irq/irq_collect.sv
// Interrupt collector
// Registers timer and external sources into pending, masks them with enable,
// and offers a claim word and one combined interrupt output

`timescale 1ns/1ps

module irq_collect
    import periph_pkg::*;
#(
    parameter int NUM_TIMERS  = 2,
    parameter int NUM_EXT_IRQ = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  reg_req_t               req_i,
    input  logic [NUM_TIMERS-1:0]  tmr_irq_i,
    input  logic [NUM_EXT_IRQ-1:0] ext_irq_i,
    output reg_rsp_t               rsp_o,
    output logic                   irq_o
);

    localparam int NUM_SRC = NUM_TIMERS + NUM_EXT_IRQ;  // Timers in the low bits

    localparam logic [OFFS_W-1:0] REG_PENDING = 8'd0;
    localparam logic [OFFS_W-1:0] REG_ENABLE  = 8'd1;
    localparam logic [OFFS_W-1:0] REG_CLAIM   = 8'd2;

    logic [NUM_SRC-1:0] pending_q;
    logic [NUM_SRC-1:0] enable_q;
    logic [NUM_SRC-1:0] active;
    logic [DATA_W-1:0]  enable_new;
    logic [DATA_W-1:0]  claim;
    logic               wr_en;

    assign wr_en      = req_i.valid && req_i.write && (req_i.slot == IRQ);
    assign enable_new = apply_strb(DATA_W'(enable_q), req_i.wdata, req_i.wstrb);
    assign active     = pending_q & enable_q;
    assign irq_o      = |active;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            pending_q <= {ext_irq_i, tmr_irq_i};
            if (wr_en && (req_i.offset == REG_ENABLE)) begin
                enable_q <= enable_new[NUM_SRC-1:0];
            end
        end
    end

    // Lowest active source wins, reported as index plus one
    always_comb begin
        claim = '0;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (active[i]) claim = DATA_W'(i + 1);
        end
    end

    always_comb begin
        rsp_o.resp = RESP_OKAY;
        case (req_i.offset)
            REG_PENDING: rsp_o.rdata = DATA_W'(pending_q);
            REG_ENABLE:  rsp_o.rdata = DATA_W'(enable_q);
            REG_CLAIM:   rsp_o.rdata = claim;
            default:     rsp_o.rdata = '0;
        endcase
    end

endmodule

// File: logic/periph_resp_select.sv
// Response select
// Registers the response of the addressed block on each request;
// accesses to an absent slot answer with SLVERR and a marker word

`timescale 1ns/1ps

module periph_resp_select
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  reg_req_t req_i,
    input  reg_rsp_t timer_rsp_i,
    input  reg_rsp_t irq_rsp_i,
    output reg_rsp_t rsp_o
);

    reg_rsp_t rsp_q;
    reg_rsp_t rsp_d;

    always_comb begin
        case (req_i.slot)
            TIMER: rsp_d = timer_rsp_i;
            IRQ:   rsp_d = irq_rsp_i;
            default: begin
                rsp_d.rdata = ABSENT_DATA;
                rsp_d.resp  = RESP_SLVERR;
            end
        endcase
    end

    // Held until the next request
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_q <= '0;
        end else if (req_i.valid) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o = rsp_q;

endmodule

// File: logic/periph_top.sv
// Peripheral subsystem top
// AXI4-Lite slave with a timer bank and an interrupt collector behind it

`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
#(
    parameter int NUM_TIMERS  = 2,
    parameter int NUM_EXT_IRQ = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [ADDR_W-1:0]      awaddr_i,
    input  logic                   awvalid_i,
    output logic                   awready_o,
    input  logic [DATA_W-1:0]      wdata_i,
    input  logic [STRB_W-1:0]      wstrb_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,
    output logic [1:0]             bresp_o,
    output logic                   bvalid_o,
    input  logic                   bready_i,
    input  logic [ADDR_W-1:0]      araddr_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    output logic [DATA_W-1:0]      rdata_o,
    output logic [1:0]             rresp_o,
    output logic                   rvalid_o,
    input  logic                   rready_i,
    input  logic [NUM_EXT_IRQ-1:0] irq_i,
    output logic                   irq_o
);

    reg_req_t              req;
    reg_rsp_t              timer_rsp;
    reg_rsp_t              irq_rsp;
    reg_rsp_t              sel_rsp;
    logic [NUM_TIMERS-1:0] tmr_irq;

    axil_reg_bridge i_axil_reg_bridge (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .awaddr_i  ( awaddr_i  ),
        .awvalid_i ( awvalid_i ),
        .awready_o ( awready_o ),
        .wdata_i   ( wdata_i   ),
        .wstrb_i   ( wstrb_i   ),
        .wvalid_i  ( wvalid_i  ),
        .wready_o  ( wready_o  ),
        .bresp_o   ( bresp_o   ),
        .bvalid_o  ( bvalid_o  ),
        .bready_i  ( bready_i  ),
        .araddr_i  ( araddr_i  ),
        .arvalid_i ( arvalid_i ),
        .arready_o ( arready_o ),
        .rdata_o   ( rdata_o   ),
        .rresp_o   ( rresp_o   ),
        .rvalid_o  ( rvalid_o  ),
        .rready_i  ( rready_i  ),
        .rsp_i     ( sel_rsp   ),
        .req_o     ( req       )
    );

    timer_bank #(
        .NUM_TIMERS ( NUM_TIMERS )
    ) i_timer_bank (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .req_i     ( req       ),
        .rsp_o     ( timer_rsp ),
        .tmr_irq_o ( tmr_irq   )
    );

    irq_collect #(
        .NUM_TIMERS  ( NUM_TIMERS  ),
        .NUM_EXT_IRQ ( NUM_EXT_IRQ )
    ) i_irq_collect (
        .clk_i     ( clk_i   ),
        .rst_i     ( rst_i   ),
        .req_i     ( req     ),
        .tmr_irq_i ( tmr_irq ),
        .ext_irq_i ( irq_i   ),
        .rsp_o     ( irq_rsp ),
        .irq_o     ( irq_o   )
    );

    periph_resp_select i_periph_resp_select (
        .clk_i       ( clk_i     ),
        .rst_i       ( rst_i     ),
        .req_i       ( req       ),
        .timer_rsp_i ( timer_rsp ),
        .irq_rsp_i   ( irq_rsp   ),
        .rsp_o       ( sel_rsp   )
    );

endmodule

// File: verif/tb_clk_gen.sv
// Testbench clock and reset source
// Free running clock, reset held high for the first few cycles

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;
        rst_o = 1'b0;
    end

endmodule

// File: verif/periph_tb.sv
// Testbench for the peripheral subsystem
// AXI4-Lite accesses and interrupt inputs against a register model

`timescale 1ns/1ps

module periph_tb
    import periph_pkg::*;
();

    localparam int NUM_TIMERS  = 2;
    localparam int NUM_EXT_IRQ = 4;
    localparam int NUM_SRC     = NUM_TIMERS + NUM_EXT_IRQ;
    localparam int HS_TIMEOUT  = 20;
    localparam int RSP_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 60;

    logic                   clk_i;
    logic                   rst_i;
    logic [ADDR_W-1:0]      awaddr_i;
    logic                   awvalid_i;
    logic                   awready_o;
    logic [DATA_W-1:0]      wdata_i;
    logic [STRB_W-1:0]      wstrb_i;
    logic                   wvalid_i;
    logic                   wready_o;
    logic [1:0]             bresp_o;
    logic                   bvalid_o;
    logic                   bready_i;
    logic [ADDR_W-1:0]      araddr_i;
    logic                   arvalid_i;
    logic                   arready_o;
    logic [DATA_W-1:0]      rdata_o;
    logic [1:0]             rresp_o;
    logic                   rvalid_o;
    logic                   rready_i;
    logic [NUM_EXT_IRQ-1:0] irq_i;
    logic                   irq_o;

    // Register model
    logic [DATA_W-1:0]      m_compare [NUM_TIMERS];
    logic [NUM_TIMERS-1:0]  m_enable;
    logic [NUM_TIMERS-1:0]  m_match;
    logic [NUM_SRC-1:0]     m_irq_en;
    logic [NUM_EXT_IRQ-1:0] m_ext;

    // Results waiting for the compare process
    reg_rsp_t          act_q  [$];
    reg_rsp_t          exp_q  [$];
    logic              data_q [$];
    logic [ADDR_W-1:0] addr_q [$];
    reg_rsp_t          c_act;
    reg_rsp_t          c_exp;
    logic              c_dat;
    logic [ADDR_W-1:0] c_addr;

    int                errors;
    int                checks;
    int                err_mark;
    logic              timed_out;
    integer            seed;
    logic [DATA_W-1:0] rnd;
    logic [DATA_W-1:0] cmp;
    logic [ADDR_W-1:0] base;
    reg_rsp_t          got;
    logic              done;
    int                polls;
    int                stall;
    int                n;

    tb_clk_gen #(
        .PERIOD_NS  ( 40 ),
        .RST_CYCLES ( 3  )
    ) i_tb_clk_gen (
        .clk_o ( clk_i ),
        .rst_o ( rst_i )
    );

    periph_top #(
        .NUM_TIMERS  ( NUM_TIMERS  ),
        .NUM_EXT_IRQ ( NUM_EXT_IRQ )
    ) i_periph_top (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .awaddr_i  ( awaddr_i  ),
        .awvalid_i ( awvalid_i ),
        .awready_o ( awready_o ),
        .wdata_i   ( wdata_i   ),
        .wstrb_i   ( wstrb_i   ),
        .wvalid_i  ( wvalid_i  ),
        .wready_o  ( wready_o  ),
        .bresp_o   ( bresp_o   ),
        .bvalid_o  ( bvalid_o  ),
        .bready_i  ( bready_i  ),
        .araddr_i  ( araddr_i  ),
        .arvalid_i ( arvalid_i ),
        .arready_o ( arready_o ),
        .rdata_o   ( rdata_o   ),
        .rresp_o   ( rresp_o   ),
        .rvalid_o  ( rvalid_o  ),
        .rready_i  ( rready_i  ),
        .irq_i     ( irq_i     ),
        .irq_o     ( irq_o     )
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic logic ref_irq();
        return |({m_ext, m_match} & m_irq_en);
    endfunction

    function automatic reg_rsp_t ref_read(input logic [ADDR_W-1:0] addr);
        reg_rsp_t           r;
        int                 idx;
        logic [NUM_SRC-1:0] act;
        r.resp  = RESP_OKAY;
        r.rdata = '0;
        idx     = int'(addr[7:4]);
        act     = {m_ext, m_match} & m_irq_en;
        if (addr[11:8] == SLOT_TIMER) begin
            if (idx < NUM_TIMERS) begin
                case (addr[3:2])
                    2'd1:    r.rdata = m_compare[idx];
                    2'd2:    r.rdata = DATA_W'(m_enable[idx]);
                    2'd3:    r.rdata = DATA_W'(m_match[idx]);
                    default: r.rdata = '0;    // Counter is not modeled
                endcase
            end
        end else if (addr[11:8] == SLOT_IRQ) begin
            case (addr[7:2])
                6'd0: r.rdata = DATA_W'({m_ext, m_match});
                6'd1: r.rdata = DATA_W'(m_irq_en);
                6'd2: begin
                    for (int i = 0; i < NUM_SRC; i++) begin
                        if (act[i] && r.rdata == '0) r.rdata = DATA_W'(i + 1);
                    end
                end
                default: r.rdata = '0;
            endcase
        end else begin
            r.resp  = RESP_SLVERR;
            r.rdata = ABSENT_DATA;
        end
        return r;
    endfunction

    function automatic void model_write(
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data,
        input logic [STRB_W-1:0] strb
    );
        int                idx;
        logic [DATA_W-1:0] en_word;
        idx     = int'(addr[7:4]);
        en_word = merge_bytes(DATA_W'(m_irq_en), data, strb);
        if (addr[11:8] == SLOT_TIMER && idx < NUM_TIMERS) begin
            case (addr[3:2])
                2'd1:    m_compare[idx] = merge_bytes(m_compare[idx], data, strb);
                2'd2:    if (strb[0]) m_enable[idx] = data[0];
                2'd3:    if (strb[0] && data[0]) m_match[idx] = 1'b0;
                default: ;
            endcase
        end else if (addr[11:8] == SLOT_IRQ && addr[7:2] == 6'd1) begin
            m_irq_en = en_word[NUM_SRC-1:0];
        end
    endfunction

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------
    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        timed_out = 1'b1;
    endtask

    task automatic bus_access(
        input  logic              is_write,
        input  logic [ADDR_W-1:0] addr,
        input  logic [DATA_W-1:0] data,
        input  logic [STRB_W-1:0] strb,
        input  int                stall_cycles,
        output reg_rsp_t          rsp
    );
        int   waited;
        int   lat;
        int   k;
        logic seen;
        rsp = '0;
        if (timed_out) return;
        @(posedge clk_i);
        #2;
        if (is_write) begin
            awaddr_i  = addr;
            wdata_i   = data;
            wstrb_i   = strb;
            awvalid_i = 1'b1;
            wvalid_i  = 1'b1;
        end else begin
            araddr_i  = addr;
            arvalid_i = 1'b1;
        end
        waited = 0;
        seen   = 1'b0;
        while (!seen && !timed_out) begin
            @(negedge clk_i);
            seen = is_write ? (awready_o && wready_o) : arready_o;
            waited++;
            if (!seen && waited > HS_TIMEOUT) report_timeout("DUT never accepted the address");
        end
        @(posedge clk_i);
        #2;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        arvalid_i = 1'b0;
        lat  = 0;           // Cycles after the handshake cycle
        seen = 1'b0;
        while (!seen && !timed_out) begin
            @(negedge clk_i);
            lat++;
            seen = is_write ? bvalid_o : rvalid_o;
            if (!seen && lat > RSP_TIMEOUT) report_timeout("DUT never raised its response valid");
        end
        if (timed_out) return;
        checks++;
        assert (lat == 2) else begin
            $display("Error at %0t: response valid after %0d cycles, expected 2", $time, lat);
            errors++;
        end
        rsp.resp  = is_write ? bresp_o : rresp_o;
        rsp.rdata = is_write ? '0 : rdata_o;
        // Hold ready low and offer new requests that must not be taken
        k = 0;
        while (k < stall_cycles) begin
            @(posedge clk_i);
            #2;
            awaddr_i  = addr;
            araddr_i  = addr;
            wstrb_i   = '0;
            awvalid_i = 1'b1;
            wvalid_i  = 1'b1;
            arvalid_i = 1'b1;
            @(negedge clk_i);
            checks++;
            assert ((is_write ? (bvalid_o && bresp_o == rsp.resp)
                              : (rvalid_o && rresp_o == rsp.resp && rdata_o == rsp.rdata))
                    && !awready_o && !arready_o) else begin
                $display("Error at %0t: response changed or request taken under back-pressure",
                         $time);
                errors++;
            end
            k++;
        end
        @(posedge clk_i);
        #2;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        arvalid_i = 1'b0;
        bready_i  = is_write;
        rready_i  = !is_write;
        @(posedge clk_i);   // B or R transfer completes here
        #2;
        bready_i  = 1'b0;
        rready_i  = 1'b0;
    endtask

    task automatic check_write(
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data,
        input logic [STRB_W-1:0] strb,
        input int                stall_cycles
    );
        reg_rsp_t exp;
        reg_rsp_t rsp;
        exp = ref_read(addr);
        bus_access(1'b1, addr, data, strb, stall_cycles, rsp);
        model_write(addr, data, strb);
        if (!timed_out) begin
            act_q.push_back(rsp);
            exp_q.push_back(exp);
            data_q.push_back(1'b0);     // Only the response code counts
            addr_q.push_back(addr);
        end
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] addr, input int stall_cycles);
        reg_rsp_t exp;
        reg_rsp_t rsp;
        exp = ref_read(addr);
        bus_access(1'b0, addr, '0, '0, stall_cycles, rsp);
        if (!timed_out) begin
            act_q.push_back(rsp);
            exp_q.push_back(exp);
            data_q.push_back(1'b1);
            addr_q.push_back(addr);
        end
    endtask

    task automatic wait_irq_level(input logic level, input string what);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && !timed_out) begin
            @(negedge clk_i);
            seen = (irq_o == level);
            waited++;
            if (!seen && waited > POLL_LIMIT) report_timeout(what);
        end
    endtask

    task automatic drain_checks();
        int waited;
        waited = 0;
        while (act_q.size() != 0 && waited < 5) begin
            @(posedge clk_i);
            waited++;
        end
        if (act_q.size() != 0) report_timeout("compare queue did not drain");
    endtask

    task automatic end_test(input string name);
        drain_checks();
        $display("%-24s done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // Compare process
    always @(posedge clk_i) begin
        while (act_q.size() != 0) begin
            c_act  = act_q.pop_front();
            c_exp  = exp_q.pop_front();
            c_dat  = data_q.pop_front();
            c_addr = addr_q.pop_front();
            checks++;
            assert (c_act.resp == c_exp.resp && (!c_dat || c_act.rdata == c_exp.rdata)) else begin
                $display("Error at %0t: addr 0x%03h got %0d/0x%08h, exp %0d/0x%08h",
                         $time, c_addr, c_act.resp, c_act.rdata, c_exp.resp, c_exp.rdata);
                errors++;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        awaddr_i  = '0;
        awvalid_i = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        wvalid_i  = 1'b0;
        bready_i  = 1'b0;
        araddr_i  = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b0;
        irq_i     = '0;
        m_compare = '{default: '0};
        m_enable  = '0;
        m_match   = '0;
        m_irq_en  = '0;
        m_ext     = '0;
        errors    = 0;
        checks    = 0;
        err_mark  = 0;
        timed_out = 1'b0;
        seed      = 32'he21cbef6;

        n = 0;
        @(posedge clk_i);
        while (rst_i && n < 10) begin
            @(posedge clk_i);
            n++;
        end
        if (rst_i) report_timeout("reset was never released");
        @(negedge clk_i);
        checks++;
        assert (!bvalid_o && !rvalid_o && !irq_o) else begin
            $display("Error at %0t: outputs not idle after reset", $time);
            errors++;
        end

        // Register read/write on both timers
        for (int t = 0; t < NUM_TIMERS; t++) begin
            base = ADDR_W'(16 * t);
            for (int r = 0; r < 3; r++) begin
                rnd = $random(seed);
                check_write(base + 12'h004, rnd, 4'hF, 0);
                check_read(base + 12'h004, 0);
                rnd = $random(seed);
                check_write(base + 12'h008, rnd, 4'hF, 0);
                check_read(base + 12'h008, 0);
            end
            rnd = $random(seed);
            check_write(base + 12'h004, rnd, 4'b0110, 0);  // Middle bytes only
            check_read(base + 12'h004, 0);
            check_write(base + 12'h008, 32'h0, 4'hF, 0);
        end
        end_test("[1] register access");

        // Absent slots answer with SLVERR
        for (int s = 2; s < 16; s++) begin
            rnd = $random(seed);
            check_write({4'(s), rnd[7:2], 2'b00}, rnd, 4'hF, 0);
            check_read({4'(s), rnd[13:8], 2'b00}, 0);
        end
        check_read(12'h004, 0);
        check_read(12'h0F4, 0);    // Beyond the last timer
        check_read(12'h104, 0);
        end_test("[2] absent slot");

        // Timer 0 match and its interrupt
        rnd = $random(seed);
        cmp = DATA_W'(rnd[2:0]) + 32'd4;
        check_write(12'h000, 32'h0, 4'hF, 0);   // Counter restarts from zero
        check_write(12'h004, cmp, 4'hF, 0);
        check_write(12'h008, 32'h1, 4'hF, 0);
        done  = 1'b0;
        polls = 0;
        while (!done && !timed_out) begin
            bus_access(1'b0, 12'h00C, '0, '0, 0, got);
            if (got.rdata[0]) begin
                done = 1'b1;
            end else begin
                polls++;
                if (polls > POLL_LIMIT) report_timeout("timer 0 never reached its compare value");
            end
        end
        m_match[0] = 1'b1;
        check_read(12'h00C, 0);
        check_write(12'h104, 32'h1, 4'h1, 0);
        wait_irq_level(1'b1, "irq_o did not rise after the timer match");
        check_read(12'h108, 0);
        check_write(12'h008, 32'h0, 4'hF, 0);
        check_write(12'h00C, 32'h1, 4'h1, 0);   // Clear match
        wait_irq_level(1'b0, "irq_o did not fall after clearing the match");
        check_read(12'h00C, 0);
        check_read(12'h108, 0);
        end_test("[3] timer match");

        // External interrupt inputs
        for (int r = 0; r < 6; r++) begin
            rnd = $random(seed);
            check_write(12'h104, DATA_W'(rnd[NUM_SRC-1:0]), 4'hF, 0);
            @(posedge clk_i);
            #2;
            irq_i = rnd[8 +: NUM_EXT_IRQ];
            m_ext = rnd[8 +: NUM_EXT_IRQ];
            @(posedge clk_i);       // Input register
            check_read(12'h100, 0);
            check_read(12'h104, 0);
            check_read(12'h108, 0);
            @(negedge clk_i);
            checks++;
            assert (irq_o == ref_irq()) else begin
                $display("Error at %0t: irq_o is %0b, expected %0b", $time, irq_o, ref_irq());
                errors++;
            end
        end
        end_test("[4] external interrupts");

        // Ready held low for a random number of cycles
        for (int r = 0; r < 4; r++) begin
            rnd   = $random(seed);
            stall = int'(rnd[2:0]) + 1;
            check_write(12'h014, rnd, 4'hF, stall);
            check_read(12'h014, stall);
            check_read(12'h3F0, stall);
        end
        end_test("[5] back-pressure");

        $display("Summary: %0d checks, %0d errors, timeout %0b", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
common/periph_pkg.sv
logic/axil_reg_bridge.sv
timer/timer_bank.sv
irq/irq_collect.sv
logic/periph_resp_select.sv
logic/periph_top.sv
verif/tb_clk_gen.sv
verif/periph_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the peripheral testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module periph_tb -o periph_tb_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/periph_tb_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported a failure"; exit 1; } || exit 0
